/* include/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data path width in bits
`define RV_XLEN 32

// Architectural integer registers
`define RV_NREGS 32

// Data memory depth in 32-bit words
`define RV_DMEM_WORDS 256

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* design/rv_pkg.sv */
`default_nettype none

package rv_pkg;

   `include "rv_defines.svh"

   // Major opcodes of the supported subset
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_BRANCH = 7'b1100011,
      OPC_JAL    = 7'b1101111
   } rv_opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_PASS_B
   } rv_alu_op_e;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rv_r_fmt_t;

   // Store and branch layout with the immediate split around the register fields
   typedef struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } rv_s_fmt_t;

   typedef union packed {
      rv_r_fmt_t r;
      rv_s_fmt_t s;
   } rv_instr_u;

   typedef struct packed {
      rv_alu_op_e alu_op;
      logic       use_imm;
      logic       reg_write;
      logic       mem_read;
      logic       mem_write;
      logic       branch;
      logic       branch_ne;
      logic       jump;
   } rv_ctrl_t;

   typedef struct packed {
      logic                valid;
      logic [`RV_XLEN-1:0] pc;
      logic [4:0]          rs1;
      logic [4:0]          rs2;
      logic [4:0]          rd;
      logic [`RV_XLEN-1:0] op1;
      logic [`RV_XLEN-1:0] op2;
      logic [`RV_XLEN-1:0] imm;
      rv_ctrl_t            ctrl;
   } rv_de_t;

   typedef struct packed {
      logic                valid;
      logic [`RV_XLEN-1:0] pc;
      logic [4:0]          rd;
      logic [`RV_XLEN-1:0] alu_result;
      logic [`RV_XLEN-1:0] store_data;
      rv_ctrl_t            ctrl;
   } rv_em_t;

   typedef struct packed {
      logic                valid;
      logic [4:0]          rd;
      logic                reg_write;
      logic [`RV_XLEN-1:0] wb_data;
   } rv_mw_t;

endpackage

`default_nettype wire

/* design/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_regfile (
   input  logic                clk,
   input  logic                reset,
   input  logic [4:0]          rs1_i,
   input  logic [4:0]          rs2_i,
   input  logic [4:0]          rd_i,
   input  logic                we_i,
   input  logic [`RV_XLEN-1:0] wd_i,
   output logic [`RV_XLEN-1:0] rd1_o,
   output logic [`RV_XLEN-1:0] rd2_o
);

   logic [`RV_XLEN-1:0] regs [`RV_NREGS];
   logic                wr_live;

   assign wr_live = we_i && (rd_i != 5'd0);

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `RV_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_live) begin
         regs[rd_i] <= wd_i;
      end
   end

   // Same-cycle write passes straight through to the readers
   assign rd1_o = (rs1_i == 5'd0) ? '0 :
                  (wr_live && rd_i == rs1_i) ? wd_i : regs[rs1_i];
   assign rd2_o = (rs2_i == 5'd0) ? '0 :
                  (wr_live && rd_i == rs2_i) ? wd_i : regs[rs2_i];

endmodule

`default_nettype wire

/* design/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_decode (
   input  rv_pkg::rv_instr_u    instr_i,
   input  logic [`RV_XLEN-1:0]  pc_i,
   input  logic                 valid_i,
   input  logic [`RV_XLEN-1:0]  rs_data1_i,
   input  logic [`RV_XLEN-1:0]  rs_data2_i,
   output logic [4:0]           rs1_o,
   output logic [4:0]           rs2_o,
   output rv_pkg::rv_de_t       de_o
);

   import rv_pkg::*;

   logic [31:0]         word;
   logic [`RV_XLEN-1:0] imm_i;
   logic [`RV_XLEN-1:0] imm_s;
   logic [`RV_XLEN-1:0] imm_b;
   logic [`RV_XLEN-1:0] imm_u;
   logic [`RV_XLEN-1:0] imm_j;
   rv_opcode_e          opc;

   assign word  = instr_i;
   assign opc   = rv_opcode_e'(instr_i.r.opcode);
   assign rs1_o = instr_i.r.rs1;
   assign rs2_o = instr_i.r.rs2;

   assign imm_i = {{20{word[31]}}, word[31:20]};
   assign imm_s = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
   // Branch offset bits are scattered over both immediate fields
   assign imm_b = {{19{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi[6], instr_i.s.imm_lo[0],
                   instr_i.s.imm_hi[5:0], instr_i.s.imm_lo[4:1], 1'b0};
   assign imm_u = {word[31:12], 12'b0};
   assign imm_j = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};

   always_comb begin
      logic known;
      rv_ctrl_t ctrl;
      logic [`RV_XLEN-1:0] imm;

      known = 1'b1;
      ctrl = '0;
      ctrl.alu_op = ALU_ADD;
      imm = imm_i;

      case (opc)
         OPC_OP: begin
            ctrl.reg_write = 1'b1;
            case (instr_i.r.funct3)
               3'b000: ctrl.alu_op = instr_i.r.funct7[5] ? ALU_SUB : ALU_ADD;
               3'b010: ctrl.alu_op = ALU_SLT;
               3'b100: ctrl.alu_op = ALU_XOR;
               3'b110: ctrl.alu_op = ALU_OR;
               3'b111: ctrl.alu_op = ALU_AND;
               default: known = 1'b0;
            endcase
         end
         OPC_OP_IMM: begin
            // ADDI only
            known = (instr_i.r.funct3 == 3'b000);
            ctrl.use_imm = 1'b1;
            ctrl.reg_write = 1'b1;
         end
         OPC_LUI: begin
            ctrl.alu_op = ALU_PASS_B;
            ctrl.use_imm = 1'b1;
            ctrl.reg_write = 1'b1;
            imm = imm_u;
         end
         OPC_LOAD: begin
            ctrl.use_imm = 1'b1;
            ctrl.reg_write = 1'b1;
            ctrl.mem_read = 1'b1;
         end
         OPC_STORE: begin
            ctrl.use_imm = 1'b1;
            ctrl.mem_write = 1'b1;
            imm = imm_s;
         end
         OPC_BRANCH: begin
            // BEQ and BNE differ in funct3 bit 0
            known = (instr_i.r.funct3[2:1] == 2'b00);
            ctrl.branch = 1'b1;
            ctrl.branch_ne = instr_i.r.funct3[0];
            imm = imm_b;
         end
         OPC_JAL: begin
            ctrl.jump = 1'b1;
            ctrl.reg_write = 1'b1;
            imm = imm_j;
         end
         default: known = 1'b0;
      endcase

      de_o.valid = valid_i & known;
      de_o.pc    = pc_i;
      de_o.rs1   = instr_i.r.rs1;
      de_o.rs2   = instr_i.r.rs2;
      de_o.rd    = instr_i.r.rd;
      de_o.op1   = rs_data1_i;
      de_o.op2   = rs_data2_i;
      de_o.imm   = imm;
      de_o.ctrl  = known ? ctrl : '0;
   end

endmodule

`default_nettype wire

/* design/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_execute (
   input  rv_pkg::rv_de_t       de_i,
   input  logic [4:0]           res_rd_i,
   input  logic                 res_write_i,
   input  logic [`RV_XLEN-1:0]  res_data_i,
   input  logic [4:0]           wb_rd_i,
   input  logic                 wb_write_i,
   input  logic [`RV_XLEN-1:0]  wb_data_i,
   output rv_pkg::rv_em_t       em_o,
   output logic                 redirect_o,
   output logic [`RV_XLEN-1:0]  target_o
);

   import rv_pkg::*;

   logic [`RV_XLEN-1:0] src_a;
   logic [`RV_XLEN-1:0] src_b;
   logic [`RV_XLEN-1:0] alu_b;
   logic [`RV_XLEN-1:0] alu_out;
   logic                equal;
   logic                taken;

   // Youngest producer wins and x0 is never forwarded
   function automatic logic [`RV_XLEN-1:0] fwd_sel(
      input logic [4:0]          rs,
      input logic [`RV_XLEN-1:0] rf_val,
      input logic [4:0]          r_rd,
      input logic                r_we,
      input logic [`RV_XLEN-1:0] r_data,
      input logic [4:0]          w_rd,
      input logic                w_we,
      input logic [`RV_XLEN-1:0] w_data
   );
      if (rs == 5'd0) begin
         return rf_val;
      end else if (r_we && r_rd == rs) begin
         return r_data;
      end else if (w_we && w_rd == rs) begin
         return w_data;
      end
      return rf_val;
   endfunction

   assign src_a = fwd_sel(de_i.rs1, de_i.op1, res_rd_i, res_write_i, res_data_i,
                          wb_rd_i, wb_write_i, wb_data_i);
   assign src_b = fwd_sel(de_i.rs2, de_i.op2, res_rd_i, res_write_i, res_data_i,
                          wb_rd_i, wb_write_i, wb_data_i);
   assign alu_b = de_i.ctrl.use_imm ? de_i.imm : src_b;

   always_comb begin
      case (de_i.ctrl.alu_op)
         ALU_SUB:    alu_out = src_a - alu_b;
         ALU_AND:    alu_out = src_a & alu_b;
         ALU_OR:     alu_out = src_a | alu_b;
         ALU_XOR:    alu_out = src_a ^ alu_b;
         ALU_SLT:    alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(src_a) < $signed(alu_b)};
         ALU_PASS_B: alu_out = alu_b;
         default:    alu_out = src_a + alu_b;
      endcase
   end

   assign equal = (src_a == src_b);
   assign taken = de_i.ctrl.jump | (de_i.ctrl.branch & (equal ^ de_i.ctrl.branch_ne));

   assign redirect_o = de_i.valid & taken;
   assign target_o   = de_i.pc + de_i.imm;

   always_comb begin
      em_o.valid      = de_i.valid;
      em_o.pc         = de_i.pc;
      em_o.rd         = de_i.rd;
      // Link address for JAL
      em_o.alu_result = de_i.ctrl.jump ? de_i.pc + `RV_XLEN'd4 : alu_out;
      em_o.store_data = src_b;
      em_o.ctrl       = de_i.ctrl;
   end

endmodule

`default_nettype wire

/* design/rv_result.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_result (
   input  logic                clk,
   input  logic                reset,
   input  rv_pkg::rv_em_t      em_i,
   output rv_pkg::rv_mw_t      mw_o,
   output logic [`RV_XLEN-1:0] fwd_data_o
);

   import rv_pkg::*;

   localparam int AW = $clog2(`RV_DMEM_WORDS);

   logic [`RV_XLEN-1:0] mem [`RV_DMEM_WORDS];
   logic [AW-1:0]       idx;
   logic [`RV_XLEN-1:0] load_data;

   // Word address wraps at the memory depth
   assign idx = em_i.alu_result[AW+1:2];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else if (em_i.valid && em_i.ctrl.mem_write) begin
         mem[idx] <= em_i.store_data;
      end
   end

   assign load_data = mem[idx];

   // Also feeds execute so a dependent op right after a load needs no stall
   assign fwd_data_o = em_i.ctrl.mem_read ? load_data : em_i.alu_result;

   always_comb begin
      mw_o.valid     = em_i.valid;
      mw_o.rd        = em_i.rd;
      mw_o.reg_write = em_i.ctrl.reg_write;
      mw_o.wb_data   = fwd_data_o;
   end

endmodule

`default_nettype wire

/* design/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_core (
   input  logic                clk,
   input  logic                reset,
   output logic [`RV_XLEN-1:0] imem_addr_o,
   input  logic [31:0]         imem_data_i,
   output logic                wb_en_o,
   output logic [4:0]          wb_rd_o,
   output logic [`RV_XLEN-1:0] wb_data_o
);

   import rv_pkg::*;

   logic [`RV_XLEN-1:0] pc_q;

   // Fetch register
   logic                if_valid_q;
   logic [`RV_XLEN-1:0] if_pc_q;
   rv_instr_u           if_instr_q;

   rv_de_t              de_d, de_q;
   rv_em_t              em_d, em_q;
   rv_mw_t              mw_d, mw_q;

   logic [4:0]          rs1, rs2;
   logic [`RV_XLEN-1:0] rs_data1, rs_data2;
   logic [`RV_XLEN-1:0] res_fwd;
   logic                redirect;
   logic [`RV_XLEN-1:0] target;
   logic                wb_write;

   assign imem_addr_o = pc_q;
   assign wb_write    = mw_q.valid & mw_q.reg_write;

   always_ff @(posedge clk) begin
      if_pc_q    <= pc_q;
      if_instr_q <= imem_data_i;
   end

   // Taken branch squashes the fetch and decode slots
   always_ff @(posedge clk) begin
      if (reset) begin
         pc_q       <= `RV_RESET_PC;
         if_valid_q <= 1'b0;
         de_q       <= '0;
         em_q       <= '0;
         mw_q       <= '0;
      end else begin
         pc_q       <= redirect ? target : pc_q + `RV_XLEN'd4;
         if_valid_q <= ~redirect;
         de_q       <= de_d;
         if (redirect) begin
            de_q.valid <= 1'b0;
         end
         em_q       <= em_d;
         mw_q       <= mw_d;
      end
   end

   rv_decode decode_i (
      .instr_i    (if_instr_q),
      .pc_i       (if_pc_q),
      .valid_i    (if_valid_q),
      .rs_data1_i (rs_data1),
      .rs_data2_i (rs_data2),
      .rs1_o      (rs1),
      .rs2_o      (rs2),
      .de_o       (de_d)
   );

   rv_regfile regfile_i (
      .clk   (clk),
      .reset (reset),
      .rs1_i (rs1),
      .rs2_i (rs2),
      .rd_i  (mw_q.rd),
      .we_i  (wb_write),
      .wd_i  (mw_q.wb_data),
      .rd1_o (rs_data1),
      .rd2_o (rs_data2)
   );

   rv_execute execute_i (
      .de_i        (de_q),
      .res_rd_i    (em_q.rd),
      .res_write_i (em_q.valid & em_q.ctrl.reg_write),
      .res_data_i  (res_fwd),
      .wb_rd_i     (mw_q.rd),
      .wb_write_i  (wb_write),
      .wb_data_i   (mw_q.wb_data),
      .em_o        (em_d),
      .redirect_o  (redirect),
      .target_o    (target)
   );

   rv_result result_i (
      .clk        (clk),
      .reset      (reset),
      .em_i       (em_q),
      .mw_o       (mw_d),
      .fwd_data_o (res_fwd)
   );

   assign wb_en_o   = wb_write & (mw_q.rd != 5'd0);
   assign wb_rd_o   = mw_q.rd;
   assign wb_data_o = mw_q.wb_data;

endmodule

`default_nettype wire

/* sim/rv_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_checker (
   input  logic        clk,
   input  logic        reset,
   input  logic        wb_en_i,
   input  logic [4:0]  wb_rd_i,
   input  logic [31:0] wb_data_i,
   input  logic        clear_i,
   input  logic        push_i,
   input  logic [4:0]  push_rd_i,
   input  logic [31:0] push_data_i,
   output int          pending_o,
   output int          errors_o
);

   typedef struct packed {
      logic [4:0]  rd;
      logic [31:0] data;
   } wb_pair_t;

   wb_pair_t exp_q [$];

   initial begin
      pending_o = 0;
      errors_o  = 0;
   end

   always @(posedge clk) begin
      wb_pair_t exp;

      if (clear_i) begin
         exp_q.delete();
      end else if (push_i) begin
         exp_q.push_back({push_rd_i, push_data_i});
      end

      // Writebacks are compared in program order
      if (!reset && wb_en_i === 1'b1) begin
         if (exp_q.size() == 0) begin
            $display("Unexpected writeback at %0t: x%0d = 0x%08h, none was expected",
                     $time, wb_rd_i, wb_data_i);
            errors_o = errors_o + 1;
         end else begin
            exp = exp_q.pop_front();
            if (wb_rd_i !== exp.rd) begin
               $display("[ERROR] %0t: writeback to x%0d, expected x%0d",
                        $time, wb_rd_i, exp.rd);
               errors_o = errors_o + 1;
            end else if (wb_data_i !== exp.data) begin
               $display("[ERROR] %0t: x%0d = 0x%08h, expected 0x%08h",
                        $time, wb_rd_i, wb_data_i, exp.data);
               errors_o = errors_o + 1;
            end
         end
      end

      pending_o = exp_q.size();
   end

endmodule

`default_nettype wire

/* sim/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

   localparam int N_TESTS     = 6;
   localparam int PROG_MAX    = 12;
   localparam int IMEM_WORDS  = 256;
   localparam int DRAIN_LIMIT = 200;
   localparam int SETTLE      = 10;

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OPI    = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [31:0] NOP       = 32'h0000_0013;

   logic        clk;
   logic        reset;
   logic [31:0] imem_addr;
   logic [31:0] imem_data;
   logic        wb_en;
   logic [4:0]  wb_rd;
   logic [31:0] wb_data;
   logic        clear;
   logic        push;
   logic [4:0]  push_rd;
   logic [31:0] push_data;
   int          pending;
   int          errors;

   logic [31:0] imem [IMEM_WORDS];
   logic [15:0] lfsr_state;

   string       test_name [N_TESTS];
   logic [31:0] prog_words [N_TESTS][PROG_MAX];
   int          prog_len [N_TESTS];
   logic [4:0]  exp_rd [N_TESTS][PROG_MAX];
   logic [31:0] exp_data [N_TESTS][PROG_MAX];
   int          exp_count [N_TESTS];

   assign imem_data = imem[imem_addr[9:2]];

   rv_core dut_i (
      .clk         (clk),
      .reset       (reset),
      .imem_addr_o (imem_addr),
      .imem_data_i (imem_data),
      .wb_en_o     (wb_en),
      .wb_rd_o     (wb_rd),
      .wb_data_o   (wb_data)
   );

   rv_checker wb_check_i (
      .clk         (clk),
      .reset       (reset),
      .wb_en_i     (wb_en),
      .wb_rd_i     (wb_rd),
      .wb_data_i   (wb_data),
      .clear_i     (clear),
      .push_i      (push),
      .push_rd_i   (push_rd),
      .push_data_i (push_data),
      .pending_o   (pending),
      .errors_o    (errors)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, OPC_OP};
   endfunction

   function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
   endfunction

   function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
   endfunction

   function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
   endfunction

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic take_random_bits(input int n, output logic [31:0] bits);
      bits = '0;
      for (int i = 0; i < n; i++) begin
         bits = {bits[30:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);
      end
   endtask

   task automatic add_word(input int t, input logic [31:0] w);
      prog_words[t][prog_len[t]] = w;
      prog_len[t] = prog_len[t] + 1;
   endtask

   task automatic expect_write(input int t, input logic [4:0] rd, input logic [31:0] data);
      exp_rd[t][exp_count[t]] = rd;
      exp_data[t][exp_count[t]] = data;
      exp_count[t] = exp_count[t] + 1;
   endtask

   task automatic build_table;
      logic [31:0] x [32];
      logic [31:0] r;
      logic [11:0] imm;
      logic [31:0] acc;

      for (int t = 0; t < N_TESTS; t++) begin
         prog_len[t] = 0;
         exp_count[t] = 0;
      end

      // Back to back ALU chain
      test_name[0] = "alu_chain";
      x[1] = 32'd100;
      x[2] = x[1] - 32'd7;
      x[3] = 32'h1234_5000;
      x[4] = x[3] + x[2];
      x[5] = x[4] - x[1];
      x[6] = x[5] & x[4];
      x[7] = x[6] | x[3];
      x[8] = x[7] ^ x[5];
      x[9] = {31'b0, $signed(x[2]) < $signed(x[1])};
      x[10] = 32'hFFFF_FFFF;
      x[11] = {31'b0, $signed(x[10]) < $signed(x[9])};
      x[12] = {31'b0, $signed(x[1]) < $signed(x[2])};
      add_word(0, i_type(12'd100, 0, 3'b000, 1, OPC_OPI));
      add_word(0, i_type(-12'sd7, 1, 3'b000, 2, OPC_OPI));
      add_word(0, {20'h12345, 5'd3, OPC_LUI});
      add_word(0, r_type(7'h00, 2, 3, 3'b000, 4));
      add_word(0, r_type(7'h20, 1, 4, 3'b000, 5));
      add_word(0, r_type(7'h00, 4, 5, 3'b111, 6));
      add_word(0, r_type(7'h00, 3, 6, 3'b110, 7));
      add_word(0, r_type(7'h00, 5, 7, 3'b100, 8));
      add_word(0, r_type(7'h00, 1, 2, 3'b010, 9));
      add_word(0, i_type(-12'sd1, 0, 3'b000, 10, OPC_OPI));
      add_word(0, r_type(7'h00, 9, 10, 3'b010, 11));
      add_word(0, r_type(7'h00, 2, 1, 3'b010, 12));
      for (int k = 1; k <= 12; k++) begin
         expect_write(0, k[4:0], x[k]);
      end

      test_name[1] = "load_store";
      add_word(1, i_type(12'h055, 0, 3'b000, 1, OPC_OPI));
      add_word(1, i_type(12'd16, 0, 3'b000, 2, OPC_OPI));
      add_word(1, s_type(12'd0, 1, 2));
      add_word(1, i_type(12'd0, 2, 3'b010, 3, OPC_LOAD));
      add_word(1, s_type(12'd4, 2, 2));
      add_word(1, i_type(12'd4, 2, 3'b010, 4, OPC_LOAD));
      add_word(1, i_type(12'd8, 2, 3'b010, 5, OPC_LOAD));
      add_word(1, i_type(12'd0, 2, 3'b010, 6, OPC_LOAD));
      add_word(1, r_type(7'h00, 2, 6, 3'b000, 7));
      add_word(1, r_type(7'h00, 4, 7, 3'b000, 8));
      add_word(1, s_type(12'd12, 7, 2));
      add_word(1, i_type(12'd12, 2, 3'b010, 9, OPC_LOAD));
      expect_write(1, 1, 32'h55);
      expect_write(1, 2, 32'd16);
      expect_write(1, 3, 32'h55);
      expect_write(1, 4, 32'd16);
      // Word never stored and cleared at reset
      expect_write(1, 5, 32'd0);
      expect_write(1, 6, 32'h55);
      expect_write(1, 7, 32'h55 + 32'd16);
      expect_write(1, 8, 32'h55 + 32'd32);
      expect_write(1, 9, 32'h55 + 32'd16);

      test_name[2] = "branches";
      add_word(2, i_type(12'd5, 0, 3'b000, 1, OPC_OPI));
      add_word(2, i_type(12'd5, 0, 3'b000, 2, OPC_OPI));
      add_word(2, b_type(13'd12, 2, 1, 3'b000));
      add_word(2, i_type(12'd1, 0, 3'b000, 3, OPC_OPI));
      add_word(2, i_type(12'd2, 0, 3'b000, 4, OPC_OPI));
      add_word(2, b_type(13'd8, 2, 1, 3'b001));
      add_word(2, i_type(12'd3, 1, 3'b000, 5, OPC_OPI));
      add_word(2, b_type(13'd12, 1, 5, 3'b001));
      add_word(2, i_type(12'd6, 0, 3'b000, 6, OPC_OPI));
      add_word(2, i_type(12'd7, 0, 3'b000, 7, OPC_OPI));
      add_word(2, b_type(13'd8, 1, 5, 3'b000));
      add_word(2, i_type(12'd1, 5, 3'b000, 8, OPC_OPI));
      expect_write(2, 1, 32'd5);
      expect_write(2, 2, 32'd5);
      expect_write(2, 5, 32'd8);
      expect_write(2, 8, 32'd9);

      // JAL link value and then x0 as destination and source
      test_name[3] = "jal_x0";
      add_word(3, i_type(12'd1, 0, 3'b000, 1, OPC_OPI));
      add_word(3, j_type(21'd12, 2));
      add_word(3, i_type(12'd3, 0, 3'b000, 3, OPC_OPI));
      add_word(3, i_type(12'd4, 0, 3'b000, 4, OPC_OPI));
      add_word(3, i_type(12'd55, 0, 3'b000, 0, OPC_OPI));
      add_word(3, r_type(7'h00, 1, 1, 3'b000, 0));
      add_word(3, r_type(7'h00, 1, 0, 3'b000, 5));
      add_word(3, i_type(12'd9, 0, 3'b000, 6, OPC_OPI));
      add_word(3, j_type(21'd12, 0));
      add_word(3, i_type(12'd1, 0, 3'b000, 8, OPC_OPI));
      add_word(3, i_type(12'd2, 0, 3'b000, 8, OPC_OPI));
      add_word(3, i_type(12'd1, 6, 3'b000, 10, OPC_OPI));
      expect_write(3, 1, 32'd1);
      expect_write(3, 2, 32'd8);
      expect_write(3, 5, 32'd1);
      expect_write(3, 6, 32'd9);
      expect_write(3, 10, 32'd10);

      for (int t = 4; t < N_TESTS; t++) begin
         test_name[t] = (t == 4) ? "random_a" : "random_b";
         acc = '0;
         for (int i = 0; i < PROG_MAX; i++) begin
            take_random_bits(12, r);
            imm = r[11:0];
            acc = acc + {{20{imm[11]}}, imm};
            add_word(t, i_type(imm, i[4:0], 3'b000, i[4:0] + 5'd1, OPC_OPI));
            expect_write(t, i[4:0] + 5'd1, acc);
         end
      end
   endtask

   task automatic next_cycle;
      @(posedge clk);
      #1;
   endtask

   task automatic load_program(input int t);
      for (int i = 0; i < IMEM_WORDS; i++) begin
         imem[i] = NOP;
      end
      for (int i = 0; i < prog_len[t]; i++) begin
         imem[i] = prog_words[t][i];
      end
   endtask

   initial begin
      int errs_before;
      int errs;
      int cycles;
      int fail_count;
      logic timed_out;

      reset = 1'b1;
      clear = 1'b0;
      push = 1'b0;
      push_rd = '0;
      push_data = '0;
      fail_count = 0;
      lfsr_state = 16'd62895;
      for (int i = 0; i < IMEM_WORDS; i++) begin
         imem[i] = NOP;
      end
      build_table();

      for (int t = 0; t < N_TESTS; t++) begin
         next_cycle();
         reset = 1'b1;
         load_program(t);
         clear = 1'b1;
         next_cycle();
         clear = 1'b0;
         for (int k = 0; k < exp_count[t]; k++) begin
            push = 1'b1;
            push_rd = exp_rd[t][k];
            push_data = exp_data[t][k];
            next_cycle();
         end
         push = 1'b0;
         repeat (5) next_cycle();
         errs_before = errors;
         reset = 1'b0;

         cycles = 0;
         while (pending != 0 && cycles < DRAIN_LIMIT) begin
            next_cycle();
            cycles++;
         end
         timed_out = (pending != 0);
         if (timed_out) begin
            $display("Timeout: test %s still waited for %0d writebacks after %0d cycles",
                     test_name[t], pending, DRAIN_LIMIT);
         end
         // Late strays would show up here
         repeat (SETTLE) next_cycle();

         errs = errors - errs_before;
         if (timed_out || errs != 0) begin
            fail_count++;
         end
         $display("Test %-12s %s  (%0d writebacks, %0d errors)", test_name[t],
                  (timed_out || errs != 0) ? "failed" : "ok", exp_count[t], errs);
      end

      $display("Tests run %0d, failed %0d, checker errors %0d", N_TESTS, fail_count, errors);
      if (fail_count == 0 && errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_result.sv
design/rv_core.sv
sim/rv_checker.sv
sim/tb_rv_core.sv
